//--- verilog/tiny_core_settings.svh
`ifndef TINY_CORE_SETTINGS_SVH
`define TINY_CORE_SETTINGS_SVH

// datapath
`define TC_REG_W      16
`define TC_REG_N      16

// opcode, dst, src0, src1 and a low byte
`define TC_INSN_W     24

// storage depths in words
`define TC_IMEM_DEPTH 64
`define TC_DMEM_DEPTH 256

// extra cycles the data memory spends on each core access
`define TC_DMEM_WAIT  2

`endif

//--- verilog/tiny_core_pkg.sv
`default_nettype none

`include "tiny_core_settings.svh"

package tiny_core_pkg;

    typedef logic [`TC_REG_W-1:0]                reg_t;
    typedef logic [$clog2(`TC_REG_N)-1:0]        reg_idx_t;
    typedef logic [`TC_INSN_W-1:0]               insn_t;
    typedef logic [$clog2(`TC_IMEM_DEPTH)-1:0]   imem_addr_t;
    typedef logic [$clog2(`TC_DMEM_DEPTH)-1:0]   dmem_addr_t;

    // lives in insn[23:20]
    typedef enum logic [3:0] {
        NOP       = 4'h0,
        ADD       = 4'h1,
        SUB       = 4'h2,
        MUL       = 4'h3,
        AND       = 4'h4,
        OR        = 4'h5,
        XOR       = 4'h6,
        LSHIFT    = 4'h7,
        RSHIFT    = 4'h8,
        CMPGE     = 4'h9,   // last of the two-operand alu ops
        SET_CONST = 4'ha,
        LD        = 4'hb,
        ST        = 4'hc,   // store data register in insn[7:4]
        BNZ       = 4'hd,
        READY     = 4'he
    } opcode_e;

endpackage

`default_nettype wire

//--- verilog/insn_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "tiny_core_settings.svh"

module insn_memory
(
    input  wire                            clk,

    // host load port
    input  wire                            wr,
    input  wire tiny_core_pkg::imem_addr_t wr_addr,
    input  wire tiny_core_pkg::insn_t      wr_data,

    // fetch port
    input  wire tiny_core_pkg::imem_addr_t rd_addr,
    output tiny_core_pkg::insn_t           rd_data
);

    tiny_core_pkg::insn_t mem [`TC_IMEM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_addr] <= wr_data;
    end

    // fetch sees the word in the same cycle
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "tiny_core_settings.svh"

module register_file
(
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          init_r0,
    input  wire tiny_core_pkg::reg_t     init_r0_data,
    input  wire tiny_core_pkg::reg_idx_t rd_idx0,
    input  wire tiny_core_pkg::reg_idx_t rd_idx1,
    input  wire tiny_core_pkg::reg_idx_t rd_idx2,
    output tiny_core_pkg::reg_t          rd_data0,
    output tiny_core_pkg::reg_t          rd_data1,
    output tiny_core_pkg::reg_t          rd_data2,
    input  wire                          wr_en,
    input  wire tiny_core_pkg::reg_idx_t wr_idx,
    input  wire tiny_core_pkg::reg_t     wr_data
);

    tiny_core_pkg::reg_t regs [`TC_REG_N];

    // writeback wins over the stored value
    function automatic tiny_core_pkg::reg_t read_port(input tiny_core_pkg::reg_idx_t idx);
        if (wr_en && wr_idx == idx)
            return wr_data;
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `TC_REG_N; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (wr_en)
                regs[wr_idx] <= wr_data;
            if (init_r0)
                regs[0] <= init_r0_data;  // start value for r0
        end
    end

    always_comb
    begin
        rd_data0 = read_port(rd_idx0);
        rd_data1 = read_port(rd_idx1);
        rd_data2 = read_port(rd_idx2);
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "tiny_core_settings.svh"

module alu
(
    input  wire tiny_core_pkg::opcode_e opcode,
    input  wire tiny_core_pkg::reg_t    a,
    input  wire tiny_core_pkg::reg_t    b,
    input  wire [7:0]                   imm,
    output tiny_core_pkg::reg_t         result,
    output logic                        branch_taken
);

    logic [2*`TC_REG_W-1:0] product;
    logic [3:0]             shamt;

    assign product = {{`TC_REG_W{1'b0}}, a} * {{`TC_REG_W{1'b0}}, b};
    assign shamt   = b[3:0];

    always_comb
    begin
        case (opcode)
            tiny_core_pkg::ADD,
            tiny_core_pkg::LD,
            tiny_core_pkg::ST:
                result = a + b;  // ld/st address sits in the low byte
            tiny_core_pkg::SUB:
                result = a - b;
            tiny_core_pkg::MUL:
                result = product[`TC_REG_W-1:0];
            tiny_core_pkg::AND:
                result = a & b;
            tiny_core_pkg::OR:
                result = a | b;
            tiny_core_pkg::XOR:
                result = a ^ b;
            tiny_core_pkg::LSHIFT:
                result = a << shamt;
            tiny_core_pkg::RSHIFT:
                result = a >> shamt;
            tiny_core_pkg::CMPGE:
                result = {{(`TC_REG_W-1){1'b0}}, a >= b};  // unsigned
            tiny_core_pkg::SET_CONST:
                result = {{(`TC_REG_W-8){1'b0}}, imm};
            default:
                result = '0;
        endcase
    end

    assign branch_taken = (opcode == tiny_core_pkg::BNZ) && (a != '0);

endmodule

`default_nettype wire

//--- verilog/core_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

`include "tiny_core_settings.svh"

module core_pipeline
(
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            insn_wr,
    input  wire tiny_core_pkg::imem_addr_t insn_wr_addr,
    input  wire tiny_core_pkg::insn_t      insn_wr_data,
    input  wire                            start,
    input  wire tiny_core_pkg::reg_t       start_r0_data,
    output logic                           ready,
    output tiny_core_pkg::dmem_addr_t      mem_addr,
    output tiny_core_pkg::reg_t            mem_wr_data,
    output logic                           mem_rd,
    output logic                           mem_wr,
    input  wire tiny_core_pkg::reg_t       mem_rd_data,
    input  wire                            mem_ready
);

    typedef enum logic {IDLE, RUN} state_e;

    localparam int OPC_LSB = `TC_INSN_W - 4;
    localparam tiny_core_pkg::insn_t NOP_WORD   = {tiny_core_pkg::NOP, {OPC_LSB{1'b0}}};
    localparam tiny_core_pkg::insn_t READY_WORD = {tiny_core_pkg::READY, {OPC_LSB{1'b0}}};
    localparam tiny_core_pkg::imem_addr_t LAST_ADDR =
        tiny_core_pkg::imem_addr_t'(`TC_IMEM_DEPTH - 1);

    state_e                    state;
    tiny_core_pkg::imem_addr_t ip;
    logic                      fetch_last;
    tiny_core_pkg::insn_t      fetch_insn, fd_insn, dx_insn, xm_insn, mw_insn;
    tiny_core_pkg::opcode_e    fd_op, dx_op, xm_op, mw_op;
    tiny_core_pkg::reg_t       rf_a, rf_b, rf_c;
    tiny_core_pkg::reg_t       dx_a, dx_b, dx_c;
    tiny_core_pkg::reg_t       x_a, x_b, x_c, x_result;
    tiny_core_pkg::reg_t       xm_result, xm_c;
    tiny_core_pkg::reg_t       mw_result, mw_ld_data, w_result;
    logic                      accept, advance, hold_mem, load_use, stall;
    logic                      branch_taken, rf_wr;

    function automatic tiny_core_pkg::opcode_e opc(input tiny_core_pkg::insn_t insn);
        return tiny_core_pkg::opcode_e'(insn[`TC_INSN_W-1 -: 4]);
    endfunction

    function automatic logic writes_reg(input tiny_core_pkg::opcode_e op);
        return op inside {[tiny_core_pkg::ADD:tiny_core_pkg::CMPGE],
                          tiny_core_pkg::SET_CONST, tiny_core_pkg::LD};
    endfunction

    // operands read by execute other than st data
    function automatic logic reads_src0(input tiny_core_pkg::opcode_e op);
        return op inside {[tiny_core_pkg::ADD:tiny_core_pkg::CMPGE],
                          tiny_core_pkg::LD, tiny_core_pkg::ST, tiny_core_pkg::BNZ};
    endfunction

    function automatic logic reads_src1(input tiny_core_pkg::opcode_e op);
        return op inside {[tiny_core_pkg::ADD:tiny_core_pkg::CMPGE],
                          tiny_core_pkg::LD, tiny_core_pkg::ST};
    endfunction

    // a load in memory has no data yet and is covered by the stall
    function automatic tiny_core_pkg::reg_t fwd_x(input tiny_core_pkg::reg_idx_t idx,
                                                  input tiny_core_pkg::reg_t     rf_val);
        if (writes_reg(xm_op) && xm_op != tiny_core_pkg::LD && xm_insn[19:16] == idx)
            return xm_result;
        if (writes_reg(mw_op) && mw_insn[19:16] == idx)
            return w_result;
        return rf_val;
    endfunction

    assign fd_op = opc(fd_insn);
    assign dx_op = opc(dx_insn);
    assign xm_op = opc(xm_insn);
    assign mw_op = opc(mw_insn);

    assign ready    = (state == IDLE);
    assign accept   = start && ready;
    assign hold_mem = (mem_rd || mem_wr) && !mem_ready;
    assign advance  = (state == RUN) && !hold_mem;

    assign load_use = (dx_op == tiny_core_pkg::LD) &&
        ((reads_src0(fd_op) && dx_insn[19:16] == fd_insn[15:12]) ||
         (reads_src1(fd_op) && dx_insn[19:16] == fd_insn[11:8]));
    assign stall = load_use || (dx_op == tiny_core_pkg::READY);  // drain after READY

    insn_memory insn_memory_inst (
        .clk     (clk),
        .wr      (insn_wr && ready),
        .wr_addr (insn_wr_addr),
        .wr_data (insn_wr_data),
        .rd_addr (ip),
        .rd_data (fetch_insn)
    );

    assign rf_wr    = writes_reg(mw_op);
    assign w_result = (mw_op == tiny_core_pkg::LD) ? mw_ld_data : mw_result;

    register_file register_file_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_r0      (accept),
        .init_r0_data (start_r0_data),
        .rd_idx0      (fd_insn[15:12]),
        .rd_idx1      (fd_insn[11:8]),
        .rd_idx2      (fd_insn[7:4]),
        .rd_data0     (rf_a),
        .rd_data1     (rf_b),
        .rd_data2     (rf_c),
        .wr_en        (rf_wr),
        .wr_idx       (mw_insn[19:16]),
        .wr_data      (w_result)
    );

    always_comb
    begin
        x_a = fwd_x(dx_insn[15:12], dx_a);
        x_b = fwd_x(dx_insn[11:8], dx_b);
        x_c = fwd_x(dx_insn[7:4], dx_c);
    end

    alu alu_inst (
        .opcode       (dx_op),
        .a            (x_a),
        .b            (x_b),
        .imm          (dx_insn[7:0]),
        .result       (x_result),
        .branch_taken (branch_taken)
    );

    assign mem_rd   = (xm_op == tiny_core_pkg::LD);
    assign mem_wr   = (xm_op == tiny_core_pkg::ST);
    assign mem_addr = xm_result[$bits(tiny_core_pkg::dmem_addr_t)-1:0];
    // ld then st of the loaded register
    assign mem_wr_data = (mw_op == tiny_core_pkg::LD && mw_insn[19:16] == xm_insn[7:4]) ?
        mw_ld_data : xm_c;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            ip         <= '0;
            fetch_last <= 1'b0;
            fd_insn    <= NOP_WORD;
            dx_insn    <= NOP_WORD;
            xm_insn    <= NOP_WORD;
            mw_insn    <= NOP_WORD;
        end
        else if (accept)
        begin
            state      <= RUN;
            ip         <= '0;
            fetch_last <= 1'b0;
            fd_insn    <= NOP_WORD;
            dx_insn    <= NOP_WORD;
            xm_insn    <= NOP_WORD;
            mw_insn    <= NOP_WORD;
        end
        else if (advance)
        begin
            if (xm_op == tiny_core_pkg::READY)
                state <= IDLE;
            if (branch_taken)
            begin
                ip         <= dx_insn[$bits(tiny_core_pkg::imem_addr_t)-1:0];
                fetch_last <= 1'b0;
                fd_insn    <= NOP_WORD;
            end
            else if (!stall)
            begin
                ip <= ip + 1'b1;
                if (ip == LAST_ADDR)
                    fetch_last <= 1'b1;
                fd_insn <= fetch_last ? READY_WORD : fetch_insn;  // ran off the end
            end
            dx_insn <= (branch_taken || stall) ? NOP_WORD : fd_insn;
            xm_insn <= dx_insn;
            mw_insn <= xm_insn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            dx_a      <= rf_a;
            dx_b      <= rf_b;
            dx_c      <= rf_c;
            xm_result <= x_result;
            xm_c      <= x_c;
            mw_result <= xm_result;
            if (mem_rd)
                mw_ld_data <= mem_rd_data;
        end
    end

    // fetch must not run ahead of a waiting access
    ip_hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_rd || mem_wr) && !mem_ready |=> $stable(ip));

endmodule

`default_nettype wire

//--- verilog/data_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "tiny_core_settings.svh"

module data_memory
(
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire tiny_core_pkg::dmem_addr_t core_addr,
    input  wire tiny_core_pkg::reg_t       core_wr_data,
    input  wire                            core_rd,
    input  wire                            core_wr,
    output tiny_core_pkg::reg_t            core_rd_data,
    output logic                           core_ready,
    input  wire                            host_wr,
    input  wire tiny_core_pkg::dmem_addr_t host_addr,
    input  wire tiny_core_pkg::reg_t       host_wr_data,
    output tiny_core_pkg::reg_t            host_rd_data
);

    localparam int CNT_W = $clog2(`TC_DMEM_WAIT + 2);
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(`TC_DMEM_WAIT);

    tiny_core_pkg::reg_t mem [`TC_DMEM_DEPTH];
    logic [CNT_W-1:0]    wait_cnt;
    logic                core_req;

    assign core_req   = core_rd || core_wr;
    assign core_ready = core_req && (wait_cnt == WAIT_LAST);  // one cycle strobe

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wait_cnt <= '0;
        else if (core_ready || !core_req)
            wait_cnt <= '0;
        else
            wait_cnt <= wait_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (core_ready && core_wr)
            mem[core_addr] <= core_wr_data;
        if (host_wr)
            mem[host_addr] <= host_wr_data;
    end

    assign core_rd_data = mem[core_addr];
    assign host_rd_data = mem[host_addr];

    // host only touches memory while the core is stopped
    host_wr_idle: assert property (@(posedge clk) disable iff (!rst_n)
        host_wr |-> !core_req);

    core_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        core_req && !core_ready |=> core_req && $stable(core_addr));

endmodule

`default_nettype wire

//--- verilog/tiny_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module tiny_core_top
(
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            insn_wr,
    input  wire tiny_core_pkg::imem_addr_t insn_wr_addr,
    input  wire tiny_core_pkg::insn_t      insn_wr_data,
    input  wire                            start,
    input  wire tiny_core_pkg::reg_t       start_r0_data,
    output wire                            ready,
    input  wire                            host_wr,
    input  wire tiny_core_pkg::dmem_addr_t host_addr,
    input  wire tiny_core_pkg::reg_t       host_wr_data,
    output tiny_core_pkg::reg_t            host_rd_data
);

    wire tiny_core_pkg::dmem_addr_t mem_addr;
    wire tiny_core_pkg::reg_t       mem_wr_data;
    wire tiny_core_pkg::reg_t       mem_rd_data;
    wire                            mem_rd;
    wire                            mem_wr;
    wire                            mem_ready;

    core_pipeline core_pipeline_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .insn_wr       (insn_wr),
        .insn_wr_addr  (insn_wr_addr),
        .insn_wr_data  (insn_wr_data),
        .start         (start),
        .start_r0_data (start_r0_data),
        .ready         (ready),
        .mem_addr      (mem_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_rd        (mem_rd),
        .mem_wr        (mem_wr),
        .mem_rd_data   (mem_rd_data),
        .mem_ready     (mem_ready)
    );

    data_memory data_memory_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_addr    (mem_addr),
        .core_wr_data (mem_wr_data),
        .core_rd      (mem_rd),
        .core_wr      (mem_wr),
        .core_rd_data (mem_rd_data),
        .core_ready   (mem_ready),
        .host_wr      (host_wr),
        .host_addr    (host_addr),
        .host_wr_data (host_wr_data),
        .host_rd_data (host_rd_data)
    );

endmodule

`default_nettype wire

//--- verif/tiny_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tiny_core_checker
(
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            start,
    input  wire                            ready,
    input  wire tiny_core_pkg::dmem_addr_t host_addr,
    input  wire tiny_core_pkg::reg_t       host_rd_data,
    input  wire                            chk_valid,
    input  wire tiny_core_pkg::reg_t       chk_expected,
    input  wire                            test_end,
    input  wire                            run_end,
    input  wire [31:0]                     cycle_limit,
    output int                             error_count,
    output logic                           timed_out
);

    int   run_cycles;   // cycles spent with ready low, all tests
    int   tests;
    int   checks;
    int   test_checks;
    int   test_wrong;
    logic start_taken;
    logic reset_checked;

    always @(posedge clk or negedge rst_n)
    begin
        int err_now;

        if (!rst_n)
        begin
            run_cycles    <= 0;
            tests         <= 0;
            checks        <= 0;
            test_checks   <= 0;
            test_wrong    <= 0;
            start_taken   <= 1'b0;
            reset_checked <= 1'b0;
            error_count   <= 0;
            timed_out     <= 1'b0;
        end
        else
        begin
            err_now = 0;
            if (!reset_checked)
            begin
                if (!ready)
                begin
                    $display("ready is low on the first clock after reset");
                    err_now++;
                end
                reset_checked <= 1'b1;
            end

            // accepted start must drop ready on the next clock
            if (start_taken && ready)
            begin
                $display("ready stayed high one clock after an accepted start, test %0d", tests);
                err_now++;
            end
            start_taken <= start && ready;

            if (!ready)
            begin
                run_cycles <= run_cycles + 1;
                if (run_cycles + 1 >= cycle_limit && !timed_out)
                begin
                    $display("timeout: ready never returned within %0d core cycles", cycle_limit);
                    timed_out <= 1'b1;
                end
            end

            if (chk_valid)
            begin
                if (host_rd_data !== chk_expected)
                begin
                    $display("Error: host_rd_data at host_addr 0x%h is 0x%h, expected 0x%h",
                             host_addr, host_rd_data, chk_expected);
                    err_now++;
                    test_wrong <= test_wrong + 1;
                end
                test_checks <= test_checks + 1;
                checks      <= checks + 1;
            end

            if (test_end)
            begin
                $display("test %0d: %0d words checked, %0d wrong", tests, test_checks, test_wrong);
                tests       <= tests + 1;
                test_checks <= 0;
                test_wrong  <= 0;
            end

            if (run_end)
                $display("%0d tests run, %0d words checked, %0d errors", tests, checks, error_count);

            error_count <= error_count + err_now;
        end
    end

endmodule

`default_nettype wire

//--- verif/tiny_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tiny_core_settings.svh"

module tiny_core_tb;

    localparam int NUM_TESTS = 5;
    localparam int MAX_DATA  = 3;

    logic                      clk;
    logic                      rst_n;
    logic                      insn_wr;
    tiny_core_pkg::imem_addr_t insn_wr_addr;
    tiny_core_pkg::insn_t      insn_wr_data;
    logic                      start;
    tiny_core_pkg::reg_t       start_r0_data;
    wire                       ready;
    logic                      host_wr;
    tiny_core_pkg::dmem_addr_t host_addr;
    tiny_core_pkg::reg_t       host_wr_data;
    wire tiny_core_pkg::reg_t  host_rd_data;
    logic                      chk_valid;
    tiny_core_pkg::reg_t       chk_expected;
    logic                      test_end;
    logic                      run_end;
    logic [31:0]               cycle_limit;
    int                        error_count;
    logic                      timed_out;

    // program, r0, preloads and expected words per test
    tiny_core_pkg::insn_t      prog     [NUM_TESTS][`TC_IMEM_DEPTH];
    int                        prog_len [NUM_TESTS];
    tiny_core_pkg::reg_t       r0_val   [NUM_TESTS];
    tiny_core_pkg::dmem_addr_t pre_addr [NUM_TESTS][MAX_DATA];
    tiny_core_pkg::reg_t       pre_data [NUM_TESTS][MAX_DATA];
    int                        pre_n    [NUM_TESTS];
    tiny_core_pkg::dmem_addr_t exp_addr [NUM_TESTS][MAX_DATA];
    tiny_core_pkg::reg_t       exp_data [NUM_TESTS][MAX_DATA];
    int                        exp_n    [NUM_TESTS];

    always #20 clk = ~clk;

    tiny_core_top tiny_core_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .insn_wr       (insn_wr),
        .insn_wr_addr  (insn_wr_addr),
        .insn_wr_data  (insn_wr_data),
        .start         (start),
        .start_r0_data (start_r0_data),
        .ready         (ready),
        .host_wr       (host_wr),
        .host_addr     (host_addr),
        .host_wr_data  (host_wr_data),
        .host_rd_data  (host_rd_data)
    );

    tiny_core_checker tiny_core_checker_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .ready        (ready),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data),
        .chk_valid    (chk_valid),
        .chk_expected (chk_expected),
        .test_end     (test_end),
        .run_end      (run_end),
        .cycle_limit  (cycle_limit),
        .error_count  (error_count),
        .timed_out    (timed_out)
    );

    function automatic tiny_core_pkg::insn_t make_insn(input tiny_core_pkg::opcode_e op,
        input int dst, input int src0, input int src1, input int low);
        return {op, 4'(dst), 4'(src0), 4'(src1), 8'(low)};
    endfunction

    task automatic add_insn(input int t, input tiny_core_pkg::insn_t word);
        prog[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic add_preload(input int t, input int addr, input tiny_core_pkg::reg_t data);
        pre_addr[t][pre_n[t]] = 8'(addr);
        pre_data[t][pre_n[t]] = data;
        pre_n[t]++;
    endtask

    task automatic add_expect(input int t, input int addr, input tiny_core_pkg::reg_t data);
        exp_addr[t][exp_n[t]] = 8'(addr);
        exp_data[t][exp_n[t]] = data;
        exp_n[t]++;
    endtask

    task automatic build_tests();
        tiny_core_pkg::reg_t r, a, b, v2, v3, v4, v5;

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            prog_len[t] = 0;
            pre_n[t]    = 0;
            exp_n[t]    = 0;
            r0_val[t]   = tiny_core_pkg::reg_t'($urandom());
            for (int i = 0; i < `TC_IMEM_DEPTH; i++)
                prog[t][i] = '0;  // nop
        end

        // dependent alu chain off r0
        r  = r0_val[0];
        v2 = r + 16'd3;
        v3 = v2 * 16'd3;
        v4 = v3 ^ r;
        v5 = v4 << 3;
        add_insn(0, make_insn(tiny_core_pkg::SET_CONST, 1, 0, 0, 8'h03));
        add_insn(0, make_insn(tiny_core_pkg::ADD,       2, 0, 1, 0));
        add_insn(0, make_insn(tiny_core_pkg::MUL,       3, 2, 1, 0));
        add_insn(0, make_insn(tiny_core_pkg::XOR,       4, 3, 0, 0));
        add_insn(0, make_insn(tiny_core_pkg::LSHIFT,    5, 4, 1, 0));
        add_insn(0, make_insn(tiny_core_pkg::CMPGE,     6, 5, 3, 0));
        add_insn(0, make_insn(tiny_core_pkg::SET_CONST, 7, 0, 0, 8'h10));
        add_insn(0, make_insn(tiny_core_pkg::ST,        0, 7, 1, 8'h50));  // [0x13] = r5
        add_insn(0, make_insn(tiny_core_pkg::ST,        0, 7, 7, 8'h60));  // [0x20] = r6
        add_insn(0, make_insn(tiny_core_pkg::ST,        0, 1, 1, 8'h40));  // [0x06] = r4
        add_insn(0, make_insn(tiny_core_pkg::READY,     0, 0, 0, 0));
        add_expect(0, 8'h13, v5);
        add_expect(0, 8'h20, (v5 >= v3) ? 16'd1 : 16'd0);
        add_expect(0, 8'h06, v4);

        // load then immediate use
        a = tiny_core_pkg::reg_t'($urandom());
        b = tiny_core_pkg::reg_t'($urandom());
        add_preload(1, 8'h31, a);
        add_preload(1, 8'h02, b);
        add_insn(1, make_insn(tiny_core_pkg::SET_CONST, 1, 0, 0, 8'h30));
        add_insn(1, make_insn(tiny_core_pkg::SET_CONST, 2, 0, 0, 8'h01));
        add_insn(1, make_insn(tiny_core_pkg::LD,        3, 1, 2, 0));
        add_insn(1, make_insn(tiny_core_pkg::ADD,       4, 3, 0, 0));
        add_insn(1, make_insn(tiny_core_pkg::LD,        5, 2, 2, 0));
        add_insn(1, make_insn(tiny_core_pkg::SUB,       6, 5, 3, 0));
        add_insn(1, make_insn(tiny_core_pkg::ST,        0, 1, 1, 8'h40));  // [0x60] = r4
        add_insn(1, make_insn(tiny_core_pkg::ST,        0, 2, 1, 8'h60));  // [0x31] = r6
        add_insn(1, make_insn(tiny_core_pkg::READY,     0, 0, 0, 0));
        add_expect(1, 8'h60, a + r0_val[1]);
        add_expect(1, 8'h31, b - a);
        add_expect(1, 8'h02, b);

        // countdown 5..1, r4 counts fall-through writes
        add_insn(2, make_insn(tiny_core_pkg::SET_CONST, 1, 0, 0, 8'h05));
        add_insn(2, make_insn(tiny_core_pkg::SET_CONST, 2, 0, 0, 8'h01));
        add_insn(2, make_insn(tiny_core_pkg::SET_CONST, 3, 0, 0, 8'h00));
        add_insn(2, make_insn(tiny_core_pkg::SET_CONST, 4, 0, 0, 8'h00));
        add_insn(2, make_insn(tiny_core_pkg::ADD,       3, 3, 1, 0));      // loop top, addr 4
        add_insn(2, make_insn(tiny_core_pkg::SUB,       1, 1, 2, 0));
        add_insn(2, make_insn(tiny_core_pkg::BNZ,       0, 1, 0, 8'h04));
        add_insn(2, make_insn(tiny_core_pkg::ADD,       4, 4, 2, 0));
        add_insn(2, make_insn(tiny_core_pkg::ADD,       4, 4, 2, 0));
        add_insn(2, make_insn(tiny_core_pkg::AND,       5, 3, 0, 0));
        add_insn(2, make_insn(tiny_core_pkg::SET_CONST, 7, 0, 0, 8'h50));
        add_insn(2, make_insn(tiny_core_pkg::ST,        0, 7, 2, 8'h30));  // [0x51] = r3
        add_insn(2, make_insn(tiny_core_pkg::ST,        0, 7, 7, 8'h40));  // [0xa0] = r4
        add_insn(2, make_insn(tiny_core_pkg::ST,        0, 7, 1, 8'h50));  // [0x50] = r5
        add_insn(2, make_insn(tiny_core_pkg::READY,     0, 0, 0, 0));
        add_expect(2, 8'h51, 16'd15);
        add_expect(2, 8'ha0, 16'd2);
        add_expect(2, 8'h50, 16'd15 & r0_val[2]);

        // copy through load then store
        a = tiny_core_pkg::reg_t'($urandom());
        b = tiny_core_pkg::reg_t'($urandom());
        add_preload(3, 8'h70, a);
        add_preload(3, 8'h71, b);
        add_insn(3, make_insn(tiny_core_pkg::SET_CONST, 1, 0, 0, 8'h70));
        add_insn(3, make_insn(tiny_core_pkg::SET_CONST, 2, 0, 0, 8'h00));
        add_insn(3, make_insn(tiny_core_pkg::SET_CONST, 4, 0, 0, 8'h01));
        add_insn(3, make_insn(tiny_core_pkg::LD,        3, 1, 2, 0));
        add_insn(3, make_insn(tiny_core_pkg::ST,        0, 1, 1, 8'h30));  // [0xe0] = r3
        add_insn(3, make_insn(tiny_core_pkg::LD,        5, 1, 4, 0));
        add_insn(3, make_insn(tiny_core_pkg::ST,        0, 2, 2, 8'h50));  // [0x00] = r5
        add_insn(3, make_insn(tiny_core_pkg::READY,     0, 0, 0, 0));
        add_expect(3, 8'he0, a);
        add_expect(3, 8'h00, b);

        // full memory, no READY word
        prog_len[4] = `TC_IMEM_DEPTH;
        prog[4][0]  = make_insn(tiny_core_pkg::SET_CONST, 1, 0, 0, 8'h5a);
        prog[4][1]  = make_insn(tiny_core_pkg::SET_CONST, 2, 0, 0, 8'h21);
        prog[4][`TC_IMEM_DEPTH-2] = make_insn(tiny_core_pkg::ST, 0, 2, 2, 8'h10);
        add_preload(4, 8'h42, tiny_core_pkg::reg_t'($urandom()));
        add_expect(4, 8'h42, 16'h005a);
    endtask

    task automatic run_test(input int t);
        for (int i = 0; i < prog_len[t]; i++)
        begin
            @(posedge clk);
            insn_wr      <= 1'b1;
            insn_wr_addr <= tiny_core_pkg::imem_addr_t'(i);
            insn_wr_data <= prog[t][i];
        end
        for (int i = 0; i < pre_n[t]; i++)
        begin
            @(posedge clk);
            insn_wr      <= 1'b0;
            host_wr      <= 1'b1;
            host_addr    <= pre_addr[t][i];
            host_wr_data <= pre_data[t][i];
        end
        @(posedge clk);
        insn_wr       <= 1'b0;
        host_wr       <= 1'b0;
        start         <= 1'b1;
        start_r0_data <= r0_val[t];
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        while (!ready)
            @(posedge clk);
        for (int i = 0; i < exp_n[t]; i++)
        begin
            host_addr    <= exp_addr[t][i];
            chk_expected <= exp_data[t][i];
            chk_valid    <= 1'b1;
            @(posedge clk);
        end
        chk_valid <= 1'b0;
        test_end  <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial
    begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        insn_wr       = 1'b0;
        insn_wr_addr  = '0;
        insn_wr_data  = '0;
        start         = 1'b0;
        start_r0_data = '0;
        host_wr       = 1'b0;
        host_addr     = '0;
        host_wr_data  = '0;
        chk_valid     = 1'b0;
        chk_expected  = '0;
        test_end      = 1'b0;
        run_end       = 1'b0;
        void'($urandom(24001));
        build_tests();
        cycle_limit = 200;  // pipeline fill and drain margin
        for (int t = 0; t < NUM_TESTS; t++)
            cycle_limit = cycle_limit + prog_len[t] * (`TC_DMEM_WAIT + 4);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);

        @(posedge clk);
        run_end <= 1'b1;
        @(posedge clk);
        run_end <= 1'b0;
        @(posedge clk);
        if (error_count == 0 && !timed_out)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        wait (timed_out === 1'b1);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tiny_core.f
+incdir+verilog
verilog/tiny_core_pkg.sv
verilog/insn_memory.sv
verilog/register_file.sv
verilog/alu.sv
verilog/core_pipeline.sv
verilog/data_memory.sv
verilog/tiny_core_top.sv
verif/tiny_core_checker.sv
verif/tiny_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tiny_core_tb
FILELIST  = tiny_core.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
